// ==== hw/icache_pkg.sv ====
/*
  Sizes, derived widths, data types and FSM state encodings shared by the
  instruction cache RTL. Modules refer to these by scoped name.
*/
`default_nettype none

package icache_pkg;

  // Fetch port and cache line geometry
  localparam int unsigned FETCH_AW   = 32;
  localparam int unsigned FETCH_DW   = 32;
  localparam int unsigned LINE_WIDTH = 64;
  localparam int unsigned LINE_COUNT = 8;

  // Derived widths
  localparam int unsigned FETCH_ALIGN = $clog2(FETCH_DW / 8);
  localparam int unsigned LINE_ALIGN  = $clog2(LINE_WIDTH / 8);
  localparam int unsigned COUNT_ALIGN = $clog2(LINE_COUNT);
  localparam int unsigned TAG_WIDTH   = FETCH_AW - LINE_ALIGN - COUNT_ALIGN;

  typedef logic [FETCH_AW-1:0]    addr_t;
  typedef logic [FETCH_DW-1:0]    word_t;
  typedef logic [LINE_WIDTH-1:0]  line_t;
  typedef logic [TAG_WIDTH-1:0]   tag_t;
  typedef logic [COUNT_ALIGN-1:0] index_t;

  // Encodings as they appear on the AXI RRESP wires
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    L1_IDLE, L1_LOOKUP, L1_REFILL, L1_RESPOND
  } l1_state_e;

  typedef enum logic [1:0] {
    BYP_IDLE, BYP_REQUEST, BYP_WAIT, BYP_PRESENT
  } bypass_state_e;

  typedef enum logic [1:0] {
    REFILL_IDLE, REFILL_ADDR, REFILL_DATA
  } refill_state_e;

endpackage

`default_nettype wire

// ==== hw/icache_l1.sv ====
/*
  Direct-mapped L1 instruction cache. A fetch is looked up one cycle after it
  is taken. A miss requests the whole line from the refill master and installs
  it unless the refill failed. A flush clears every valid bit.
*/
`timescale 1ns/10ps
`default_nettype none

module icache_l1 (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic              fetch_valid_i,
  input  wire icache_pkg::addr_t fetch_addr_i,
  output logic                   fetch_ready_o,
  output icache_pkg::word_t      fetch_data_o,
  output logic                   fetch_error_o,
  input  wire logic              flush_valid_i,
  output logic                   flush_ready_o,
  output logic                   refill_valid_o,
  output icache_pkg::addr_t      refill_addr_o,
  input  wire logic              refill_ready_i,
  input  wire logic              refill_rsp_valid_i,
  input  wire icache_pkg::line_t refill_rsp_data_i,
  input  wire logic              refill_rsp_error_i
);

  localparam int unsigned WordsPerLine = icache_pkg::LINE_WIDTH / icache_pkg::FETCH_DW;

  icache_pkg::l1_state_e state_q, state_d;
  logic [icache_pkg::LINE_COUNT-1:0] valid_q;
  logic req_sent_q;

  icache_pkg::tag_t  tag_q  [icache_pkg::LINE_COUNT];
  icache_pkg::line_t line_q [icache_pkg::LINE_COUNT];
  icache_pkg::addr_t addr_q;
  icache_pkg::word_t word_q;
  logic              error_q;

  icache_pkg::index_t index;
  icache_pkg::tag_t   tag;
  logic               hit;
  logic               install;
  logic [icache_pkg::LINE_ALIGN-icache_pkg::FETCH_ALIGN-1:0] word_sel;
  icache_pkg::word_t [WordsPerLine-1:0] hit_words;
  icache_pkg::word_t [WordsPerLine-1:0] rsp_words;

  assign index    = addr_q[icache_pkg::LINE_ALIGN +: icache_pkg::COUNT_ALIGN];
  assign tag      = addr_q[icache_pkg::FETCH_AW-1 -: icache_pkg::TAG_WIDTH];
  assign word_sel = addr_q[icache_pkg::LINE_ALIGN-1:icache_pkg::FETCH_ALIGN];
  assign hit      = valid_q[index] && (tag_q[index] == tag);

  assign hit_words = line_q[index];
  assign rsp_words = refill_rsp_data_i;

  // Failed refills are passed to the core but never kept
  assign install = (state_q == icache_pkg::L1_REFILL) && refill_rsp_valid_i &&
                   !refill_rsp_error_i;

  assign refill_addr_o = {addr_q[icache_pkg::FETCH_AW-1:icache_pkg::LINE_ALIGN],
                          {icache_pkg::LINE_ALIGN{1'b0}}};
  assign fetch_data_o  = word_q;
  assign fetch_error_o = error_q;

  always_comb begin
    state_d        = state_q;
    fetch_ready_o  = 1'b0;
    flush_ready_o  = 1'b0;
    refill_valid_o = 1'b0;
    unique case (state_q)
      icache_pkg::L1_IDLE: begin
        // A pending flush is served before a waiting fetch
        if (flush_valid_i) begin
          flush_ready_o = 1'b1;
        end else if (fetch_valid_i) begin
          state_d = icache_pkg::L1_LOOKUP;
        end
      end
      icache_pkg::L1_LOOKUP: begin
        state_d = hit ? icache_pkg::L1_RESPOND : icache_pkg::L1_REFILL;
      end
      icache_pkg::L1_REFILL: begin
        refill_valid_o = !req_sent_q;
        if (refill_rsp_valid_i) begin
          state_d = icache_pkg::L1_RESPOND;
        end
      end
      icache_pkg::L1_RESPOND: begin
        fetch_ready_o = 1'b1;
        state_d       = icache_pkg::L1_IDLE;
      end
      default: state_d = icache_pkg::L1_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= icache_pkg::L1_IDLE;
      valid_q    <= '0;
      req_sent_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (flush_ready_o) begin
        valid_q <= '0;
      end else if (install) begin
        valid_q[index] <= 1'b1;
      end
      if (state_q == icache_pkg::L1_LOOKUP) begin
        req_sent_q <= 1'b0;
      end else if (refill_valid_o && refill_ready_i) begin
        req_sent_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == icache_pkg::L1_IDLE) && !flush_valid_i && fetch_valid_i) begin
      addr_q <= fetch_addr_i;
    end
    if (install) begin
      tag_q[index]  <= tag;
      line_q[index] <= refill_rsp_data_i;
    end
    if (state_q == icache_pkg::L1_LOOKUP) begin
      word_q  <= hit_words[word_sel];
      error_q <= 1'b0;
    end else if ((state_q == icache_pkg::L1_REFILL) && refill_rsp_valid_i) begin
      word_q  <= rsp_words[word_sel];
      error_q <= refill_rsp_error_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_bypass.sv ====
/*
  Bypass engine for uncacheable fetches. Each fetch becomes one line refill,
  the addressed word is picked from the returned line and presented to the
  core for a single cycle. Nothing is kept for later fetches.
*/
`timescale 1ns/10ps
`default_nettype none

module icache_bypass (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic              fetch_valid_i,
  input  wire icache_pkg::addr_t fetch_addr_i,
  output logic                   fetch_ready_o,
  output icache_pkg::word_t      fetch_data_o,
  output logic                   fetch_error_o,
  output logic                   refill_valid_o,
  output icache_pkg::addr_t      refill_addr_o,
  input  wire logic              refill_ready_i,
  input  wire logic              refill_rsp_valid_i,
  input  wire icache_pkg::line_t refill_rsp_data_i,
  input  wire logic              refill_rsp_error_i
);

  localparam int unsigned WordsPerLine = icache_pkg::LINE_WIDTH / icache_pkg::FETCH_DW;

  icache_pkg::bypass_state_e state_q, state_d;
  icache_pkg::word_t [WordsPerLine-1:0] rsp_words;
  icache_pkg::word_t data_q;
  logic              error_q;

  // The core holds the address for the whole fetch, so it is used directly
  assign refill_addr_o = {fetch_addr_i[icache_pkg::FETCH_AW-1:icache_pkg::LINE_ALIGN],
                          {icache_pkg::LINE_ALIGN{1'b0}}};
  assign rsp_words     = refill_rsp_data_i;
  assign fetch_data_o  = data_q;
  assign fetch_error_o = error_q;

  always_comb begin
    state_d        = state_q;
    refill_valid_o = 1'b0;
    fetch_ready_o  = 1'b0;
    unique case (state_q)
      icache_pkg::BYP_IDLE: begin
        if (fetch_valid_i) state_d = icache_pkg::BYP_REQUEST;
      end
      icache_pkg::BYP_REQUEST: begin
        refill_valid_o = 1'b1;
        if (refill_ready_i) state_d = icache_pkg::BYP_WAIT;
      end
      icache_pkg::BYP_WAIT: begin
        if (refill_rsp_valid_i) state_d = icache_pkg::BYP_PRESENT;
      end
      // Answer comes from the registers and lasts one cycle
      icache_pkg::BYP_PRESENT: begin
        fetch_ready_o = 1'b1;
        state_d       = icache_pkg::BYP_IDLE;
      end
      default: state_d = icache_pkg::BYP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= icache_pkg::BYP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == icache_pkg::BYP_WAIT) && refill_rsp_valid_i) begin
      data_q  <= rsp_words[fetch_addr_i[icache_pkg::LINE_ALIGN-1:icache_pkg::FETCH_ALIGN]];
      error_q <= refill_rsp_error_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_refill.sv ====
/*
  Refill master shared by the L1 and the bypass engine. It grants one
  requester at a time in round-robin order, reads the line over AXI4-Lite
  and returns it to the owner with a one-cycle response pulse.
*/
`timescale 1ns/10ps
`default_nettype none

module icache_refill (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  input  wire logic                  l1_valid_i,
  input  wire icache_pkg::addr_t     l1_addr_i,
  output logic                       l1_ready_o,
  output logic                       l1_rsp_valid_o,
  input  wire logic                  byp_valid_i,
  input  wire icache_pkg::addr_t     byp_addr_i,
  output logic                       byp_ready_o,
  output logic                       byp_rsp_valid_o,
  output icache_pkg::line_t          rsp_data_o,
  output logic                       rsp_error_o,
  output icache_pkg::addr_t          axi_araddr_o,
  output logic                       axi_arvalid_o,
  input  wire logic                  axi_arready_i,
  input  wire icache_pkg::line_t     axi_rdata_i,
  input  wire icache_pkg::axi_resp_e axi_rresp_i,
  input  wire logic                  axi_rvalid_i,
  output logic                       axi_rready_o
);

  icache_pkg::refill_state_e state_q;
  logic owner_byp_q;
  logic rsp_valid_q;
  logic grant_byp;
  logic grant;

  icache_pkg::addr_t araddr_q;
  icache_pkg::line_t rdata_q;
  logic              error_q;

  // The bypass wins when it is alone or when the L1 was served last
  assign grant_byp = byp_valid_i && (!l1_valid_i || !owner_byp_q);
  assign grant     = (state_q == icache_pkg::REFILL_IDLE) && (l1_valid_i || byp_valid_i);

  assign l1_ready_o  = grant && !grant_byp;
  assign byp_ready_o = grant && grant_byp;

  assign axi_araddr_o  = araddr_q;
  assign axi_arvalid_o = (state_q == icache_pkg::REFILL_ADDR);
  assign axi_rready_o  = (state_q == icache_pkg::REFILL_DATA);

  assign l1_rsp_valid_o  = rsp_valid_q && !owner_byp_q;
  assign byp_rsp_valid_o = rsp_valid_q && owner_byp_q;
  assign rsp_data_o      = rdata_q;
  assign rsp_error_o     = error_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= icache_pkg::REFILL_IDLE;
      owner_byp_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      unique case (state_q)
        icache_pkg::REFILL_IDLE: begin
          if (grant) begin
            owner_byp_q <= grant_byp;
            state_q     <= icache_pkg::REFILL_ADDR;
          end
        end
        icache_pkg::REFILL_ADDR: begin
          if (axi_arready_i) state_q <= icache_pkg::REFILL_DATA;
        end
        icache_pkg::REFILL_DATA: begin
          if (axi_rvalid_i) begin
            rsp_valid_q <= 1'b1;
            state_q     <= icache_pkg::REFILL_IDLE;
          end
        end
        default: state_q <= icache_pkg::REFILL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      araddr_q <= grant_byp ? byp_addr_i : l1_addr_i;
    end
    if (axi_rready_o && axi_rvalid_i) begin
      rdata_q <= axi_rdata_i;
      error_q <= (axi_rresp_i != icache_pkg::OKAY);
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
/*
  Instruction cache top level. Cacheable fetches go to the direct-mapped L1,
  uncacheable ones to the bypass engine, and both share one AXI4-Lite read
  master for their line refills.
*/
`timescale 1ns/10ps
`default_nettype none

module icache_top (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  input  wire logic                  inst_valid_i,
  input  wire icache_pkg::addr_t     inst_addr_i,
  input  wire logic                  inst_cacheable_i,
  output logic                       inst_ready_o,
  output icache_pkg::word_t          inst_data_o,
  output logic                       inst_error_o,
  input  wire logic                  flush_valid_i,
  output logic                       flush_ready_o,
  output icache_pkg::addr_t          axi_araddr_o,
  output logic                       axi_arvalid_o,
  input  wire logic                  axi_arready_i,
  input  wire icache_pkg::line_t     axi_rdata_i,
  input  wire icache_pkg::axi_resp_e axi_rresp_i,
  input  wire logic                  axi_rvalid_i,
  output logic                       axi_rready_o
);

  logic              l1_fetch_valid, l1_fetch_ready, l1_fetch_error;
  icache_pkg::word_t l1_fetch_data;
  logic              byp_fetch_valid, byp_fetch_ready, byp_fetch_error;
  icache_pkg::word_t byp_fetch_data;

  logic              l1_refill_valid, l1_refill_ready, l1_rsp_valid;
  icache_pkg::addr_t l1_refill_addr;
  logic              byp_refill_valid, byp_refill_ready, byp_rsp_valid;
  icache_pkg::addr_t byp_refill_addr;
  icache_pkg::line_t rsp_data;
  logic              rsp_error;

  // Route the fetch by its cacheable flag and take the answer from the same side
  assign l1_fetch_valid  = inst_valid_i & inst_cacheable_i;
  assign byp_fetch_valid = inst_valid_i & ~inst_cacheable_i;

  assign inst_ready_o = inst_cacheable_i ? l1_fetch_ready : byp_fetch_ready;
  assign inst_data_o  = inst_cacheable_i ? l1_fetch_data  : byp_fetch_data;
  assign inst_error_o = inst_cacheable_i ? l1_fetch_error : byp_fetch_error;

  icache_l1 icache_l1_inst (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .fetch_valid_i      (l1_fetch_valid),
    .fetch_addr_i       (inst_addr_i),
    .fetch_ready_o      (l1_fetch_ready),
    .fetch_data_o       (l1_fetch_data),
    .fetch_error_o      (l1_fetch_error),
    .flush_valid_i      (flush_valid_i),
    .flush_ready_o      (flush_ready_o),
    .refill_valid_o     (l1_refill_valid),
    .refill_addr_o      (l1_refill_addr),
    .refill_ready_i     (l1_refill_ready),
    .refill_rsp_valid_i (l1_rsp_valid),
    .refill_rsp_data_i  (rsp_data),
    .refill_rsp_error_i (rsp_error)
  );

  icache_bypass icache_bypass_inst (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .fetch_valid_i      (byp_fetch_valid),
    .fetch_addr_i       (inst_addr_i),
    .fetch_ready_o      (byp_fetch_ready),
    .fetch_data_o       (byp_fetch_data),
    .fetch_error_o      (byp_fetch_error),
    .refill_valid_o     (byp_refill_valid),
    .refill_addr_o      (byp_refill_addr),
    .refill_ready_i     (byp_refill_ready),
    .refill_rsp_valid_i (byp_rsp_valid),
    .refill_rsp_data_i  (rsp_data),
    .refill_rsp_error_i (rsp_error)
  );

  icache_refill icache_refill_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .l1_valid_i      (l1_refill_valid),
    .l1_addr_i       (l1_refill_addr),
    .l1_ready_o      (l1_refill_ready),
    .l1_rsp_valid_o  (l1_rsp_valid),
    .byp_valid_i     (byp_refill_valid),
    .byp_addr_i      (byp_refill_addr),
    .byp_ready_o     (byp_refill_ready),
    .byp_rsp_valid_o (byp_rsp_valid),
    .rsp_data_o      (rsp_data),
    .rsp_error_o     (rsp_error),
    .axi_araddr_o    (axi_araddr_o),
    .axi_arvalid_o   (axi_arvalid_o),
    .axi_arready_i   (axi_arready_i),
    .axi_rdata_i     (axi_rdata_i),
    .axi_rresp_i     (axi_rresp_i),
    .axi_rvalid_i    (axi_rvalid_i),
    .axi_rready_o    (axi_rready_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
/*
  Free-running clock for the instruction cache testbench, 20 ns period.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  localparam int unsigned HALF_PERIOD_NS = 10;

  initial clk_o = 1'b0;

  always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== verification/axi_mem_model.sv ====
/*
  AXI4-Lite read slave for the testbench. Line contents are computed from the
  address, reads with the top address bit set answer SLVERR, both channels
  stall for a random number of cycles and accepted addresses are counted.
*/
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model (
  input  wire logic             clk_i,
  input  wire logic [31:0]      axi_araddr_i,
  input  wire logic             axi_arvalid_i,
  output logic                  axi_arready_o,
  output logic [63:0]           axi_rdata_o,
  output icache_pkg::axi_resp_e axi_rresp_o,
  output logic                  axi_rvalid_o,
  input  wire logic             axi_rready_i,
  output logic [31:0]           ar_count_o
);

  localparam logic [31:0] DATA_KEY    = 32'ha5a5_0000;
  localparam int unsigned MAX_STALL   = 3;
  localparam int unsigned ERROR_BIT   = 31;
  localparam int unsigned DRIVE_DELAY = 2;

  integer      seed = 32'he55173d5;
  logic [31:0] line_addr;
  int          stall;

  // Every word holds its own byte address scrambled with a fixed key
  function automatic logic [31:0] word_at(input logic [31:0] byte_addr);
    return byte_addr ^ DATA_KEY;
  endfunction

  task automatic next_drive_point();
    @(posedge clk_i);
    #(DRIVE_DELAY);
  endtask

  initial begin
    axi_arready_o = 1'b0;
    axi_rvalid_o  = 1'b0;
    axi_rdata_o   = '0;
    axi_rresp_o   = icache_pkg::OKAY;
    ar_count_o    = '0;
    forever begin
      @(negedge clk_i);
      if (axi_arvalid_i) begin
        line_addr = axi_araddr_i;
        stall     = $unsigned($random(seed)) % (MAX_STALL + 1);
        repeat (stall + 1) next_drive_point();
        axi_arready_o = 1'b1;
        next_drive_point();
        axi_arready_o = 1'b0;
        ar_count_o    = ar_count_o + 32'd1;

        // Data beat after its own random delay
        stall = $unsigned($random(seed)) % (MAX_STALL + 1);
        repeat (stall) next_drive_point();
        axi_rdata_o  = {word_at(line_addr + 32'd4), word_at(line_addr)};
        axi_rresp_o  = line_addr[ERROR_BIT] ? icache_pkg::SLVERR : icache_pkg::OKAY;
        axi_rvalid_o = 1'b1;
        do @(negedge clk_i); while (!axi_rready_i);
        next_drive_point();
        axi_rvalid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/icache_properties.sv ====
/*
  Concurrent assertions on the instruction cache top-level ports. Bound to
  every icache_top instance.
*/
`timescale 1ns/10ps
`default_nettype none

module icache_properties (
  input wire logic        clk_i,
  input wire logic        arst_n_i,
  input wire logic        inst_valid_i,
  input wire logic        inst_ready_i,
  input wire logic        flush_valid_i,
  input wire logic        flush_ready_i,
  input wire logic [31:0] araddr_i,
  input wire logic        arvalid_i,
  input wire logic        arready_i
);

  localparam int unsigned LINE_OFFSET_BITS = 3;

  araddr_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    arvalid_i |-> (araddr_i[LINE_OFFSET_BITS-1:0] == '0))
    else $error("AXI read address is not line aligned");

  // The address phase may not change or drop before the slave takes it
  ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (arvalid_i && !arready_i) |=> (arvalid_i && $stable(araddr_i)))
    else $error("AXI read address phase changed before arready");

  fetch_ready_with_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    inst_ready_i |-> inst_valid_i)
    else $error("Fetch ready raised without a fetch request");

  flush_ready_with_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_ready_i |-> flush_valid_i)
    else $error("Flush ready raised without a flush request");

endmodule

bind icache_top icache_properties icache_properties_inst (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .inst_valid_i  (inst_valid_i),
  .inst_ready_i  (inst_ready_o),
  .flush_valid_i (flush_valid_i),
  .flush_ready_i (flush_ready_o),
  .araddr_i      (axi_araddr_o),
  .arvalid_i     (axi_arvalid_o),
  .arready_i     (axi_arready_i)
);

`default_nettype wire

// ==== verification/tb_icache.sv ====
/*
  Testbench top for the instruction cache. Runs directed tests on hits,
  bypass fetches, flushes, refill errors, conflicts and a random mix against
  a computed AXI4-Lite memory.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_icache;

  localparam int unsigned CLK_PERIOD_NS    = 20;
  localparam int unsigned RESET_CYCLES     = 16;
  localparam int unsigned DRIVE_DELAY      = 2;
  localparam int unsigned DIRECTED_FETCHES = 12;
  localparam int unsigned RANDOM_FETCHES   = 40;
  localparam int unsigned CYCLES_PER_FETCH = 40;
  localparam int unsigned WATCHDOG_CYCLES  =
    RESET_CYCLES + (DIRECTED_FETCHES + RANDOM_FETCHES) * CYCLES_PER_FETCH;
  localparam logic [31:0] DATA_KEY         = 32'ha5a5_0000;
  localparam logic [31:0] ERROR_REGION     = 32'h8000_0000;

  logic                  clk;
  logic                  arst_n;
  logic                  inst_valid;
  logic [31:0]           inst_addr;
  logic                  inst_cacheable;
  logic                  inst_ready;
  logic [31:0]           inst_data;
  logic                  inst_error;
  logic                  flush_valid;
  logic                  flush_ready;
  logic [31:0]           axi_araddr;
  logic                  axi_arvalid;
  logic                  axi_arready;
  logic [63:0]           axi_rdata;
  icache_pkg::axi_resp_e axi_rresp;
  logic                  axi_rvalid;
  logic                  axi_rready;
  logic [31:0]           ar_count;

  integer      seed = 32'he55173d5;
  string       test_name;
  logic [31:0] got_data;
  logic        got_error;
  int          got_cycles;

  tb_clock_gen clock_gen_inst (.clk_o(clk));

  axi_mem_model mem_model_inst (
    .clk_i         (clk),
    .axi_araddr_i  (axi_araddr),
    .axi_arvalid_i (axi_arvalid),
    .axi_arready_o (axi_arready),
    .axi_rdata_o   (axi_rdata),
    .axi_rresp_o   (axi_rresp),
    .axi_rvalid_o  (axi_rvalid),
    .axi_rready_i  (axi_rready),
    .ar_count_o    (ar_count)
  );

  icache_top icache_top_inst (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .inst_valid_i     (inst_valid),
    .inst_addr_i      (inst_addr),
    .inst_cacheable_i (inst_cacheable),
    .inst_ready_o     (inst_ready),
    .inst_data_o      (inst_data),
    .inst_error_o     (inst_error),
    .flush_valid_i    (flush_valid),
    .flush_ready_o    (flush_ready),
    .axi_araddr_o     (axi_araddr),
    .axi_arvalid_o    (axi_arvalid),
    .axi_arready_i    (axi_arready),
    .axi_rdata_i      (axi_rdata),
    .axi_rresp_i      (axi_rresp),
    .axi_rvalid_i     (axi_rvalid),
    .axi_rready_o     (axi_rready)
  );

  // Word the memory holds at the word-aligned address of a fetch
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ DATA_KEY;
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED in %s, %s: expected %h, actual %h",
               test_name, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Drives one fetch handshake and counts the cycles until the ready pulse
  task automatic fetch(input logic [31:0] addr, input logic cacheable);
    inst_addr      = addr;
    inst_cacheable = cacheable;
    inst_valid     = 1'b1;
    got_cycles     = 0;
    @(negedge clk);
    while (!inst_ready) begin
      @(negedge clk);
      got_cycles++;
    end
    got_data  = inst_data;
    got_error = inst_error;
    @(posedge clk);
    #(DRIVE_DELAY);
    inst_valid = 1'b0;
  endtask

  task automatic fetch_expect(input logic [31:0] addr, input logic cacheable,
                              input logic error, input int unsigned reads);
    logic [31:0] count_before;
    count_before = ar_count;
    fetch(addr, cacheable);
    if (!error) begin
      check("data", expected_word(addr), got_data);
    end
    check("error flag", 32'(error), 32'(got_error));
    check("read addresses", reads, ar_count - count_before);
  endtask

  task automatic flush_cache();
    flush_valid = 1'b1;
    @(negedge clk);
    while (!flush_ready) @(negedge clk);
    @(posedge clk);
    #(DRIVE_DELAY);
    flush_valid = 1'b0;
  endtask

  task automatic hit_after_miss();
    test_name = "cacheable_hit";
    fetch_expect(32'h0000_1000, 1'b1, 1'b0, 1);
    fetch_expect(32'h0000_1004, 1'b1, 1'b0, 0);
    check("hit latency", 32'd2, 32'(got_cycles));
  endtask

  task automatic uncacheable_refetch();
    test_name = "uncacheable";
    repeat (2) fetch_expect(32'h0000_2004, 1'b0, 1'b0, 1);
  endtask

  task automatic flush_then_miss();
    test_name = "flush";
    fetch_expect(32'h0000_1000, 1'b1, 1'b0, 0);
    flush_cache();
    fetch_expect(32'h0000_1000, 1'b1, 1'b0, 1);
  endtask

  // Failed lines stay out of the cache, so every retry reads again
  task automatic error_region_retry();
    test_name = "error_region";
    repeat (2) fetch_expect(ERROR_REGION | 32'h0000_0040, 1'b1, 1'b1, 1);
  endtask

  task automatic index_conflict();
    test_name = "conflict";
    repeat (2) begin
      fetch_expect(32'h0000_0100, 1'b1, 1'b0, 1);
      fetch_expect(32'h0000_4100, 1'b1, 1'b0, 1);
    end
  endtask

  task automatic random_mix();
    logic [31:0] addr;
    logic [31:0] bits;
    test_name = "random_mix";
    repeat (RANDOM_FETCHES) begin
      addr = $random(seed) & 32'h0000_01fc;
      bits = $random(seed);
      fetch(addr, bits[0]);
      check("data", expected_word(addr), got_data);
      check("error flag", 32'd0, 32'(got_error));
    end
  endtask

  initial begin
    arst_n         = 1'b0;
    inst_valid     = 1'b0;
    inst_addr      = '0;
    inst_cacheable = 1'b0;
    flush_valid    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    arst_n = 1'b1;
    @(negedge clk);
    test_name = "reset";
    check("idle handshakes", 32'd0, 32'({inst_ready, flush_ready, axi_arvalid, axi_rready}));
    @(posedge clk);
    #(DRIVE_DELAY);

    hit_after_miss();
    uncacheable_refetch();
    flush_then_miss();
    error_region_retry();
    index_conflict();
    random_mix();

    $display("TEST PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Watchdog expired after %0d cycles while the tests were still running",
             WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

// ==== icache_top.f ====
hw/icache_pkg.sv
hw/icache_l1.sv
hw/icache_bypass.sv
hw/icache_refill.sv
hw/icache_top.sv
verification/tb_clock_gen.sv
verification/axi_mem_model.sv
verification/icache_properties.sv
verification/tb_icache.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= icache_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
